/* verilog/cache_params.svh */
// cache sizes shared by the package and all cache modules
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word address and data
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32
`define CACHE_NBYTES 4

// direct-mapped geometry, 16 lines of 4 words
`define CACHE_LINES_W 4
`define CACHE_OFFSET_W 2
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_LINES_W - `CACHE_OFFSET_W)

// write-through buffer holds 4 entries
`define CACHE_WTB_DEPTH_W 2

`endif

/* verilog/cache_pkg.sv */
// cache package with request, command, event types and the state enums
`include "cache_params.svh"

package cache_pkg;

   typedef struct packed {
      logic [`CACHE_ADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0] wdata;
      logic [`CACHE_NBYTES-1:0] wstrb;
      logic                     we;
   } fe_req_t;

   // one word transfer on the memory port
   typedef struct packed {
      logic                     we;
      logic [`CACHE_ADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0] data;
      logic [`CACHE_NBYTES-1:0] strb;
   } be_cmd_t;

   typedef struct packed {
      logic [`CACHE_ADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0] data;
      logic [`CACHE_NBYTES-1:0] strb;
   } wtb_entry_t;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_event_t;

   // control space, selected by the low address bits
   typedef enum logic [2:0] {
      CTRL_READ_HIT   = 3'd0,
      CTRL_READ_MISS  = 3'd1,
      CTRL_WRITE_HIT  = 3'd2,
      CTRL_WRITE_MISS = 3'd3,
      CTRL_WTB_EMPTY  = 3'd4,
      CTRL_INVALIDATE = 3'd5,
      CTRL_RESET_CNT  = 3'd6
   } ctrl_reg_e;

   typedef enum logic [2:0] {IDLE, LOOKUP, WAIT_WTB, REFILL, RESPOND} mem_state_e;

   typedef enum logic [1:0] {ARB_NONE, ARB_WTB, ARB_REFILL} arb_owner_e;

endpackage

/* verilog/cache_front_end.sv */
// cache front end, registers one request and steers it to the cache or control space
`include "cache_params.svh"

module cache_front_end (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   // native front-end port
   input  logic                        avalid_i,
   input  logic [`CACHE_ADDR_W:0]      addr_i,
   input  logic [`CACHE_DATA_W-1:0]    wdata_i,
   input  logic [`CACHE_NBYTES-1:0]    wstrb_i,
   output logic                        ready_o,
   output logic [`CACHE_DATA_W-1:0]    rdata_o,
   output logic                        rvalid_o,
   // cache memory side
   output logic                        data_req_o,
   output cache_pkg::fe_req_t          data_cmd_o,
   input  logic [`CACHE_DATA_W-1:0]    data_rdata_i,
   input  logic                        data_ack_i,
   // control side
   output logic                        ctrl_req_o,
   output cache_pkg::ctrl_reg_e        ctrl_addr_o,
   output logic                        ctrl_we_o,
   input  logic [`CACHE_DATA_W-1:0]    ctrl_rdata_i,
   input  logic                        ctrl_ack_i
);
   import cache_pkg::*;

   logic busy_q;
   logic ctrl_sel_q;
   logic accept;
   logic done;

   assign ready_o = ~busy_q;
   assign accept  = avalid_i & ready_o;
   // the selected target ends the request
   assign done    = busy_q & (ctrl_sel_q ? ctrl_ack_i : data_ack_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q     <= 1'b0;
         ctrl_sel_q <= 1'b0;
         data_req_o <= 1'b0;
         ctrl_req_o <= 1'b0;
      end else begin
         data_req_o <= accept & ~addr_i[`CACHE_ADDR_W];
         ctrl_req_o <= accept & addr_i[`CACHE_ADDR_W];
         if (accept) begin
            busy_q     <= 1'b1;
            ctrl_sel_q <= addr_i[`CACHE_ADDR_W];
         end else if (done) begin
            busy_q <= 1'b0;
         end
      end
   end

   // request payload, held until done
   always_ff @(posedge clk_i) begin
      if (accept) begin
         data_cmd_o <= '{addr: addr_i[`CACHE_ADDR_W-1:0], wdata: wdata_i,
                         wstrb: wstrb_i, we: |wstrb_i};
      end
   end

   assign ctrl_addr_o = ctrl_reg_e'(data_cmd_o.addr[$bits(ctrl_reg_e)-1:0]);
   assign ctrl_we_o   = data_cmd_o.we;

   // writes finish silently
   assign rvalid_o = done & ~data_cmd_o.we;
   assign rdata_o  = ctrl_sel_q ? ctrl_rdata_i : data_rdata_i;

endmodule

/* verilog/cache_memory.sv */
// cache memory, direct-mapped tag and data arrays with line refill and write-through
`include "cache_params.svh"

module cache_memory (
   input  logic                                         clk_i,
   input  logic                                         arst_n_i,
   // front end
   input  logic                                         data_req_i,
   input  cache_pkg::fe_req_t                           data_cmd_i,
   output logic [`CACHE_DATA_W-1:0]                     data_rdata_o,
   output logic                                         data_ack_o,
   // write-through buffer
   output logic                                         wtb_push_o,
   output cache_pkg::wtb_entry_t                        wtb_entry_o,
   input  logic                                         wtb_full_i,
   input  logic                                         wtb_empty_i,
   // line refill through the arbiter
   output logic                                         refill_req_o,
   output logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0]     refill_addr_o,
   input  logic                                         refill_we_i,
   input  logic [`CACHE_OFFSET_W-1:0]                   refill_beat_i,
   input  logic [`CACHE_DATA_W-1:0]                     refill_word_i,
   input  logic                                         refill_done_i,
   // control
   input  logic                                         invalidate_i,
   output cache_pkg::cache_event_t                      events_o
);
   import cache_pkg::*;

   localparam int NLINES = 1 << `CACHE_LINES_W;
   localparam int NWORDS = 1 << `CACHE_OFFSET_W;

   mem_state_e state_q;
   mem_state_e state_d;

   logic [NLINES-1:0]          valid_q;
   logic [`CACHE_TAG_W-1:0]    tag_q  [NLINES];
   logic [`CACHE_DATA_W-1:0]   data_q [NLINES][NWORDS];

   logic [`CACHE_TAG_W-1:0]    tag;
   logic [`CACHE_LINES_W-1:0]  idx;
   logic [`CACHE_OFFSET_W-1:0] off;
   logic                       hit;
   logic                       lookup_rd;
   logic                       lookup_wr;

   // address split
   assign tag = data_cmd_i.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign idx = data_cmd_i.addr[`CACHE_OFFSET_W +: `CACHE_LINES_W];
   assign off = data_cmd_i.addr[`CACHE_OFFSET_W-1:0];
   assign hit = valid_q[idx] & (tag_q[idx] == tag);

   assign lookup_rd = (state_q == LOOKUP) & ~data_cmd_i.we;
   // a write waits in LOOKUP while the buffer is full
   assign lookup_wr = (state_q == LOOKUP) & data_cmd_i.we & ~wtb_full_i;

   assign events_o = '{read_hit: lookup_rd & hit, read_miss: lookup_rd & ~hit,
                       write_hit: lookup_wr & hit, write_miss: lookup_wr & ~hit};

   assign data_ack_o   = (lookup_rd & hit) | lookup_wr | (state_q == RESPOND);
   assign data_rdata_o = data_q[idx][off];

   assign wtb_push_o  = lookup_wr;
   assign wtb_entry_o = '{addr: data_cmd_i.addr, data: data_cmd_i.wdata,
                          strb: data_cmd_i.wstrb};

   assign refill_req_o  = (state_q == REFILL);
   assign refill_addr_o = data_cmd_i.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:     if (data_req_i) state_d = LOOKUP;
         LOOKUP: begin
            if (lookup_wr || (lookup_rd && hit)) begin
               state_d = IDLE;
            end else if (lookup_rd) begin
               state_d = WAIT_WTB;
            end
         end
         // older writes must reach memory before the refill reads it
         WAIT_WTB: if (wtb_empty_i) state_d = REFILL;
         REFILL:   if (refill_done_i) state_d = RESPOND;
         RESPOND:  state_d = IDLE;
         default:  state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if (invalidate_i) begin
            valid_q <= '0;
         end else if (refill_done_i) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (refill_we_i) begin
         data_q[idx][refill_beat_i] <= refill_word_i;
      end
      if (refill_done_i) begin
         tag_q[idx] <= tag;
      end
      // write hit merges the strobed bytes
      if (lookup_wr && hit) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (data_cmd_i.wstrb[b]) begin
               data_q[idx][off][8*b +: 8] <= data_cmd_i.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

/* verilog/cache_write_buffer.sv */
// write-through buffer, circular FIFO of pending writes toward memory
`include "cache_params.svh"

module cache_write_buffer (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  push_i,
   input  cache_pkg::wtb_entry_t entry_i,
   output logic                  full_o,
   output logic                  empty_o,
   output logic                  head_valid_o,
   output cache_pkg::wtb_entry_t head_o,
   input  logic                  pop_i
);
   import cache_pkg::*;

   localparam int DEPTH = 1 << `CACHE_WTB_DEPTH_W;

   wtb_entry_t                   mem_q [DEPTH];
   logic [`CACHE_WTB_DEPTH_W-1:0] wr_ptr_q;
   logic [`CACHE_WTB_DEPTH_W-1:0] rd_ptr_q;
   logic [`CACHE_WTB_DEPTH_W:0]   count_q;
   logic                          do_push;
   logic                          do_pop;

   assign full_o       = (count_q == DEPTH);
   assign empty_o      = (count_q == '0);
   assign head_valid_o = ~empty_o;
   assign head_o       = mem_q[rd_ptr_q];

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         // push and pop together leave the count alone
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) mem_q[wr_ptr_q] <= entry_i;
   end

endmodule

/* verilog/cache_back_end_arb.sv */
// back-end arbiter, shares the memory port between buffer drains and refill beats
`include "cache_params.svh"

module cache_back_end_arb (
   input  logic                                     clk_i,
   input  logic                                     arst_n_i,
   // write-through buffer
   input  logic                                     wtb_valid_i,
   input  cache_pkg::wtb_entry_t                    wtb_head_i,
   output logic                                     wtb_pop_o,
   // refill
   input  logic                                     refill_req_i,
   input  logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] refill_addr_i,
   output logic                                     refill_we_o,
   output logic [`CACHE_OFFSET_W-1:0]               refill_beat_o,
   output logic [`CACHE_DATA_W-1:0]                 refill_word_o,
   output logic                                     refill_done_o,
   // memory port
   output logic                                     be_req_o,
   output cache_pkg::be_cmd_t                       be_cmd_o,
   input  logic [`CACHE_DATA_W-1:0]                 be_rdata_i,
   input  logic                                     be_ack_i
);
   import cache_pkg::*;

   arb_owner_e                 owner_q;
   logic [`CACHE_OFFSET_W-1:0] beat_q;

   // owner only changes once the current transfer is acknowledged
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         owner_q <= ARB_NONE;
         beat_q  <= '0;
      end else begin
         case (owner_q)
            ARB_NONE: begin
               if (wtb_valid_i) begin
                  owner_q <= ARB_WTB;
               end else if (refill_req_i) begin
                  owner_q <= ARB_REFILL;
               end
            end
            ARB_WTB: if (be_ack_i) owner_q <= ARB_NONE;
            ARB_REFILL: begin
               if (be_ack_i) begin
                  owner_q <= ARB_NONE;
                  beat_q  <= beat_q + 1'b1;
               end
            end
            default: owner_q <= ARB_NONE;
         endcase
      end
   end

   assign be_req_o = (owner_q != ARB_NONE);

   always_comb begin
      if (owner_q == ARB_WTB) begin
         be_cmd_o = '{we: 1'b1, addr: wtb_head_i.addr, data: wtb_head_i.data,
                      strb: wtb_head_i.strb};
      end else begin
         be_cmd_o = '{we: 1'b0, addr: {refill_addr_i, beat_q}, data: '0, strb: '0};
      end
   end

   assign wtb_pop_o     = (owner_q == ARB_WTB) & be_ack_i;
   assign refill_we_o   = (owner_q == ARB_REFILL) & be_ack_i;
   assign refill_beat_o = beat_q;
   assign refill_word_o = be_rdata_i;
   // last beat of the line
   assign refill_done_o = refill_we_o & (beat_q == '1);

endmodule

/* verilog/cache_control.sv */
// cache control block, event counters, buffer status and software invalidate
`include "cache_params.svh"

module cache_control (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     req_i,
   input  cache_pkg::ctrl_reg_e     addr_i,
   input  logic                     we_i,
   input  cache_pkg::cache_event_t  events_i,
   input  logic                     wtb_empty_i,
   output logic [`CACHE_DATA_W-1:0] rdata_o,
   output logic                     ack_o,
   output logic                     invalidate_o
);
   import cache_pkg::*;

   logic [`CACHE_DATA_W-1:0] cnt_q [4];
   logic [3:0]               ev_vec;
   logic                     clr_cnt;

   // bit order follows the counter opcodes
   assign ev_vec  = {events_i.write_miss, events_i.write_hit,
                     events_i.read_miss, events_i.read_hit};
   assign clr_cnt = req_i & we_i & (addr_i == CTRL_RESET_CNT);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o        <= 1'b0;
         invalidate_o <= 1'b0;
         for (int i = 0; i < 4; i++) cnt_q[i] <= '0;
      end else begin
         ack_o        <= req_i;
         invalidate_o <= req_i & we_i & (addr_i == CTRL_INVALIDATE);
         for (int i = 0; i < 4; i++) begin
            if (clr_cnt) begin
               cnt_q[i] <= '0;
            end else if (ev_vec[i] && !(&cnt_q[i])) begin
               // saturate at all ones
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_i && !we_i) begin
         case (addr_i)
            CTRL_READ_HIT, CTRL_READ_MISS,
            CTRL_WRITE_HIT, CTRL_WRITE_MISS: rdata_o <= cnt_q[addr_i[1:0]];
            CTRL_WTB_EMPTY:                  rdata_o <= `CACHE_DATA_W'(wtb_empty_i);
            default:                         rdata_o <= '0;
         endcase
      end
   end

endmodule

/* verilog/cache_top.sv */
// cache top level, connects the blocks and the invalidate and empty chains
`include "cache_params.svh"

module cache_top (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   // front-end port
   input  logic                     avalid_i,
   input  logic [`CACHE_ADDR_W:0]   addr_i,
   input  logic [`CACHE_DATA_W-1:0] wdata_i,
   input  logic [`CACHE_NBYTES-1:0] wstrb_i,
   output logic                     ready_o,
   output logic [`CACHE_DATA_W-1:0] rdata_o,
   output logic                     rvalid_o,
   // chain for cascaded caches
   input  logic                     invalidate_i,
   output logic                     invalidate_o,
   input  logic                     wtb_empty_i,
   output logic                     wtb_empty_o,
   // memory port
   output logic                     be_req_o,
   output cache_pkg::be_cmd_t       be_cmd_o,
   input  logic [`CACHE_DATA_W-1:0] be_rdata_i,
   input  logic                     be_ack_i
);
   import cache_pkg::*;

   logic                     data_req;
   fe_req_t                  data_cmd;
   logic [`CACHE_DATA_W-1:0] data_rdata;
   logic                     data_ack;

   logic                     ctrl_req;
   ctrl_reg_e                ctrl_addr;
   logic                     ctrl_we;
   logic [`CACHE_DATA_W-1:0] ctrl_rdata;
   logic                     ctrl_ack;
   logic                     ctrl_invalidate;
   cache_event_t             events;

   logic                     wtb_push;
   wtb_entry_t               wtb_entry;
   logic                     wtb_full;
   logic                     wtb_empty;
   logic                     wtb_head_valid;
   wtb_entry_t               wtb_head;
   logic                     wtb_pop;

   logic                                     refill_req;
   logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] refill_addr;
   logic                                     refill_we;
   logic [`CACHE_OFFSET_W-1:0]               refill_beat;
   logic [`CACHE_DATA_W-1:0]                 refill_word;
   logic                                     refill_done;

   // chain logic stays combinational
   assign invalidate_o = ctrl_invalidate | invalidate_i;
   assign wtb_empty_o  = wtb_empty & wtb_empty_i;

   cache_front_end front_end (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .avalid_i     (avalid_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .ready_o      (ready_o),
      .rdata_o      (rdata_o),
      .rvalid_o     (rvalid_o),
      .data_req_o   (data_req),
      .data_cmd_o   (data_cmd),
      .data_rdata_i (data_rdata),
      .data_ack_i   (data_ack),
      .ctrl_req_o   (ctrl_req),
      .ctrl_addr_o  (ctrl_addr),
      .ctrl_we_o    (ctrl_we),
      .ctrl_rdata_i (ctrl_rdata),
      .ctrl_ack_i   (ctrl_ack)
   );

   cache_memory cache_memory (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .data_req_i    (data_req),
      .data_cmd_i    (data_cmd),
      .data_rdata_o  (data_rdata),
      .data_ack_o    (data_ack),
      .wtb_push_o    (wtb_push),
      .wtb_entry_o   (wtb_entry),
      .wtb_full_i    (wtb_full),
      .wtb_empty_i   (wtb_empty),
      .refill_req_o  (refill_req),
      .refill_addr_o (refill_addr),
      .refill_we_i   (refill_we),
      .refill_beat_i (refill_beat),
      .refill_word_i (refill_word),
      .refill_done_i (refill_done),
      .invalidate_i  (invalidate_o),
      .events_o      (events)
   );

   cache_write_buffer write_buffer (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .push_i       (wtb_push),
      .entry_i      (wtb_entry),
      .full_o       (wtb_full),
      .empty_o      (wtb_empty),
      .head_valid_o (wtb_head_valid),
      .head_o       (wtb_head),
      .pop_i        (wtb_pop)
   );

   cache_back_end_arb back_end_arb (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .wtb_valid_i   (wtb_head_valid),
      .wtb_head_i    (wtb_head),
      .wtb_pop_o     (wtb_pop),
      .refill_req_i  (refill_req),
      .refill_addr_i (refill_addr),
      .refill_we_o   (refill_we),
      .refill_beat_o (refill_beat),
      .refill_word_o (refill_word),
      .refill_done_o (refill_done),
      .be_req_o      (be_req_o),
      .be_cmd_o      (be_cmd_o),
      .be_rdata_i    (be_rdata_i),
      .be_ack_i      (be_ack_i)
   );

   cache_control control (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_i        (ctrl_req),
      .addr_i       (ctrl_addr),
      .we_i         (ctrl_we),
      .events_i     (events),
      .wtb_empty_i  (wtb_empty),
      .rdata_o      (ctrl_rdata),
      .ack_o        (ctrl_ack),
      .invalidate_o (ctrl_invalidate)
   );

endmodule

/* tests/mem_model.sv */
// back-end memory model, word array that acknowledges after a random delay
`include "cache_params.svh"

module mem_model (
   input  logic                     clk_i,
   input  logic                     hold_i,
   input  logic                     req_i,
   input  cache_pkg::be_cmd_t       cmd_i,
   output logic [`CACHE_DATA_W-1:0] rdata_o,
   output logic                     ack_o
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [`CACHE_DATA_W-1:0] mem_q [1 << `CACHE_ADDR_W];
   logic [31:0]              rand_q;
   logic                     busy_q;
   int                       delay_q;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   initial begin
      // fill pattern, every bit of the address shows up in the word
      for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
         mem_q[a] = {a[15:0], a[7:0], a[15:8]} ^ 32'hc3a5_0f69;
      end
      rand_q  = 32'h0e20605c;
      busy_q  = 1'b0;
      delay_q = 0;
      ack_o   = 1'b0;
      rdata_o = '0;
   end

   // one ack per request, 0 to 3 cycles late, none while held
   always @(negedge clk_i) begin
      if (ack_o) begin
         ack_o = 1'b0;
      end else if (req_i) begin
         if (!busy_q) begin
            rand_q  = lcg_step(rand_q);
            delay_q = int'(rand_q[17:16]);
            busy_q  = 1'b1;
         end
         if (delay_q > 0) begin
            delay_q--;
         end else if (!hold_i) begin
            if (cmd_i.we) begin
               for (int b = 0; b < `CACHE_NBYTES; b++) begin
                  if (cmd_i.strb[b]) begin
                     mem_q[cmd_i.addr][8*b +: 8] = cmd_i.data[8*b +: 8];
                  end
               end
            end else begin
               rdata_o = mem_q[cmd_i.addr];
            end
            ack_o  = 1'b1;
            busy_q = 1'b0;
         end
      end
   end

endmodule

/* tests/cache_tb.sv */
// cache testbench driving random traffic against a shadow memory and tag model
`include "cache_params.svh"

module cache_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import cache_pkg::*;

   localparam int WAIT_LIMIT = 300;
   localparam int SHADOW_WORDS = 256;

   logic                     clk;
   logic                     arst_n;
   logic                     avalid;
   logic [`CACHE_ADDR_W:0]   addr;
   logic [`CACHE_DATA_W-1:0] wdata;
   logic [`CACHE_NBYTES-1:0] wstrb;
   logic                     ready;
   logic [`CACHE_DATA_W-1:0] rdata;
   logic                     rvalid;
   logic                     inv_in;
   logic                     inv_out;
   logic                     empty_in;
   logic                     empty_out;
   logic                     be_req;
   be_cmd_t                  be_cmd;
   logic [`CACHE_DATA_W-1:0] be_rdata;
   logic                     be_ack;
   logic                     hold_ack;

   // shadow of memory contents and of the direct-mapped tags
   logic [`CACHE_DATA_W-1:0] shadow_mem [SHADOW_WORDS];
   logic                     sh_valid [1 << `CACHE_LINES_W];
   logic [`CACHE_TAG_W-1:0]  sh_tag [1 << `CACHE_LINES_W];
   logic [31:0]              exp_cnt [4];
   string                    cnt_name [4] = '{"read_hit counter", "read_miss counter",
                                              "write_hit counter", "write_miss counter"};
   logic [31:0]              rand_q;
   int                       checks;
   int                       errors;
   int                       timeouts;

   cache_top dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .avalid_i     (avalid),
      .addr_i       (addr),
      .wdata_i      (wdata),
      .wstrb_i      (wstrb),
      .ready_o      (ready),
      .rdata_o      (rdata),
      .rvalid_o     (rvalid),
      .invalidate_i (inv_in),
      .invalidate_o (inv_out),
      .wtb_empty_i  (empty_in),
      .wtb_empty_o  (empty_out),
      .be_req_o     (be_req),
      .be_cmd_o     (be_cmd),
      .be_rdata_i   (be_rdata),
      .be_ack_i     (be_ack)
   );

   mem_model back_mem (
      .clk_i   (clk),
      .hold_i  (hold_ack),
      .req_i   (be_req),
      .cmd_i   (be_cmd),
      .rdata_o (be_rdata),
      .ack_o   (be_ack)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] draw();
      rand_q = lcg_step(rand_q);
      return rand_q;
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("%0d ns: gave up waiting for %s", $time, what);
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!ready) report_timeout("ready_o to return high");
   endtask

   // accepted on the rising edge between the two falling edges
   task automatic send(input logic [`CACHE_ADDR_W:0] a, input logic [31:0] d,
                       input logic [3:0] s);
      wait_ready();
      avalid = 1'b1;
      addr   = a;
      wdata  = d;
      wstrb  = s;
      @(negedge clk);
      avalid = 1'b0;
   endtask

   // latency counts rising edges from acceptance to the rvalid_o edge
   task automatic read_word(input logic [`CACHE_ADDR_W:0] a, output logic [31:0] d,
                            output int lat);
      send(a, '0, 4'h0);
      lat = 1;
      while (!rvalid && lat < WAIT_LIMIT) begin
         @(negedge clk);
         lat++;
      end
      d = rdata;
      if (!rvalid) report_timeout("rvalid_o after a read");
   endtask

   task automatic cache_read(input logic [15:0] a);
      logic [31:0]               got;
      int                        lat;
      logic [`CACHE_LINES_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0]   tag;
      idx = a[`CACHE_OFFSET_W +: `CACHE_LINES_W];
      tag = a[15 -: `CACHE_TAG_W];
      read_word({1'b0, a}, got, lat);
      check_word($sformatf("rdata_o at %h", a), got, shadow_mem[a[7:0]]);
      if (sh_valid[idx] && sh_tag[idx] == tag) begin
         exp_cnt[0]++;
         check_word("read hit latency", lat, 2);
      end else begin
         exp_cnt[1]++;
         sh_valid[idx] = 1'b1;
         sh_tag[idx]   = tag;
      end
   endtask

   // write no-allocate leaves the shadow tags alone
   task automatic cache_write(input logic [15:0] a, input logic [31:0] d,
                              input logic [3:0] s);
      logic [`CACHE_LINES_W-1:0] idx;
      idx = a[`CACHE_OFFSET_W +: `CACHE_LINES_W];
      if (sh_valid[idx] && sh_tag[idx] == a[15 -: `CACHE_TAG_W]) begin
         exp_cnt[2]++;
      end else begin
         exp_cnt[3]++;
      end
      for (int b = 0; b < 4; b++) begin
         if (s[b]) shadow_mem[a[7:0]][8*b +: 8] = d[8*b +: 8];
      end
      send({1'b0, a}, d, s);
      wait_ready();
   endtask

   task automatic ctrl_read(input ctrl_reg_e op, output logic [31:0] d);
      int lat;
      read_word({1'b1, 13'h0, op}, d, lat);
      check_word("control read latency", lat, 2);
   endtask

   task automatic ctrl_write(input ctrl_reg_e op);
      send({1'b1, 13'h0, op}, '0, 4'hf);
      wait_ready();
   endtask

   task automatic check_counters();
      logic [31:0] got;
      for (int i = 0; i < 4; i++) begin
         ctrl_read(ctrl_reg_e'(i[2:0]), got);
         check_word(cnt_name[i], got, exp_cnt[i]);
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (!empty_out && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!empty_out) report_timeout("wtb_empty_o to rise");
   endtask

   task automatic compare_memory();
      for (int a = 0; a < SHADOW_WORDS; a++) begin
         check_word($sformatf("memory word %h", a[15:0]), back_mem.mem_q[a], shadow_mem[a]);
      end
   endtask

   // a few tags over a few lines give hits, misses and conflicts
   task automatic random_access();
      logic [31:0] r;
      logic [15:0] a;
      logic [3:0]  s;
      r = draw();
      a = {8'h00, r[29:28], 2'b00, r[25:24], r[21:20]};
      s = r[3:0];
      if (r[31]) begin
         if (s == 4'h0) s = 4'hf;
         cache_write(a, draw(), s);
      end else begin
         cache_read(a);
      end
   endtask

   initial begin
      logic [31:0] got;
      clk      = 1'b1;
      arst_n   = 1'b1;
      avalid   = 1'b0;
      addr     = '0;
      wdata    = '0;
      wstrb    = '0;
      inv_in   = 1'b0;
      empty_in = 1'b1;
      hold_ack = 1'b0;
      rand_q   = 32'h0e20605c;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      for (int i = 0; i < 4; i++) exp_cnt[i] = '0;
      for (int i = 0; i < (1 << `CACHE_LINES_W); i++) sh_valid[i] = 1'b0;
      @(negedge clk);
      arst_n = 1'b0;
      for (int a = 0; a < SHADOW_WORDS; a++) shadow_mem[a] = back_mem.mem_q[a];
      repeat (16) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // state right after reset
      check_word("rvalid_o", rvalid, 0);
      check_word("be_req_o", be_req, 0);
      check_word("ready_o", ready, 1);
      check_word("invalidate_o", inv_out, 0);
      check_counters();
      ctrl_read(CTRL_WTB_EMPTY, got);
      check_word("wtb empty register", got, 1);

      repeat (300) random_access();

      // same address written in order with different strobes
      cache_write(16'h0014, 32'h1111_1111, 4'hf);
      cache_write(16'h0014, 32'h2222_2222, 4'h3);
      cache_write(16'h0014, 32'h3333_3333, 4'h6);
      wait_drained();
      compare_memory();
      cache_read(16'h0014);

      check_counters();
      ctrl_write(CTRL_RESET_CNT);
      for (int i = 0; i < 4; i++) exp_cnt[i] = '0;
      check_counters();

      // a cached word misses again after a software invalidate
      cache_read(16'h0044);
      cache_read(16'h0044);
      send({1'b1, 13'h0, CTRL_INVALIDATE}, '0, 4'hf);
      begin
         int n;
         n = 0;
         while (!inv_out && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
         end
         if (!inv_out) report_timeout("invalidate_o after a control write");
      end
      @(negedge clk);
      check_word("invalidate_o", inv_out, 0);
      wait_ready();
      for (int i = 0; i < (1 << `CACHE_LINES_W); i++) sh_valid[i] = 1'b0;
      cache_read(16'h0044);
      check_counters();

      // chained invalidate passes straight through
      cache_read(16'h0044);
      inv_in = 1'b1;
      #1;
      check_word("invalidate_o", inv_out, 1);
      @(negedge clk);
      inv_in = 1'b0;
      for (int i = 0; i < (1 << `CACHE_LINES_W); i++) sh_valid[i] = 1'b0;
      cache_read(16'h0044);
      check_counters();

      // held acknowledges fill the buffer and the fifth write stalls
      empty_in = 1'b0;
      hold_ack = 1'b1;
      #1;
      check_word("wtb_empty_o", empty_out, 0);
      for (int i = 0; i < 4; i++) begin
         cache_write(16'h0080 + 16'(i), draw(), 4'hf);
      end
      // line 4 was invalidated above, so this write misses
      send(17'h00091, 32'hdead_beef, 4'hf);
      exp_cnt[3]++;
      shadow_mem[8'h91] = 32'hdead_beef;
      repeat (12) begin
         check_word("ready_o", ready, 0);
         check_word("wtb_empty_o", empty_out, 0);
         @(negedge clk);
      end
      hold_ack = 1'b0;
      wait_ready();
      check_word("wtb_empty_o", empty_out, 0);
      empty_in = 1'b1;
      wait_drained();
      compare_memory();
      check_counters();

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* cache_sys.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_front_end.sv
verilog/cache_memory.sv
verilog/cache_write_buffer.sv
verilog/cache_back_end_arb.sv
verilog/cache_control.sv
verilog/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the cache testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   -f cache_sys.f --top-module cache_tb -o cache_sim \
   && ./obj_dir/cache_sim | tee /dev/stderr | grep -q "^Verification passed$" \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation did not pass"; exit 1; }
